/* iod_bit_training.f */
rtl/bit_align_pkg.sv
rtl/lp_start_detect.sv
rtl/training_sequencer.sv
rtl/tap_sweep.sv
rtl/window_search.sv
rtl/iod_bit_training.sv
testbench/iod_monitor.sv
testbench/iod_bit_training_assertions.sv
testbench/tb_iod_bit_training.sv

/* rtl/bit_align_pkg.sv */
////////////////////////////////////////
// Bit-alignment trainer shared types
// Tap index, delay controller command and
// status words, and the eye window record
////////////////////////////////////////

package bit_align_pkg;

  ////////////////////////////////////////
  // Tap range and window store size
  ////////////////////////////////////////
  localparam int NUM_TAPS    = 128; // One history bit per tap
  localparam int MAX_WINDOWS = 3;   // Windows kept per search

  // Delay tap index, 0 to 127
  typedef logic [6:0] tap_t;

  // Command word to the delay controller
  typedef struct packed {
    logic load;      // Tap back to 0
    logic move;      // One-cycle step
    logic dir;       // 1 steps upward
    logic clr_flags; // Clears sticky early/late
  } iod_ctrl_t;

  // Status from the delay controller
  typedef struct packed {
    logic early; // Sticky, data sampled early
    logic late;  // Sticky, data sampled late
    logic oor;   // Tap at its top end
  } iod_status_t;

  // One eye opening, as history indexes
  typedef struct packed {
    tap_t first;
    tap_t last;
  } window_t;

endpackage

/* rtl/iod_bit_training.sv */
////////////////////////////////////////
// Receive lane bit-alignment trainer
// Sweeps the input delay, finds the widest
// eye and parks the tap at its centre
////////////////////////////////////////
`timescale 1ns/10ps

module iod_bit_training import bit_align_pkg::*; #(
  parameter int MIN_WINDOW = 10,
  parameter int FAIL_LIMIT = 4,
  parameter int PWRUP_BITS = 10
) (
  input  logic        sclk,
  input  logic        reset,
  input  logic        lp_in,
  input  logic        skip_trng,
  input  iod_status_t iod_status,
  output iod_ctrl_t   iod_ctrl,
  output logic        trng_done,
  output logic        trng_fail,
  output window_t     window,   // Debug, chosen eye
  output tap_t        set_index // Debug, final tap
);

  logic                arm;
  logic                lp_start;
  logic                skip;
  logic                sweep_go;
  logic                load_go;
  logic                search_go;
  logic                sweep_done;
  logic                load_done;
  logic                search_done;
  logic                found;
  tap_t                target;
  tap_t                center;
  window_t             best;
  logic [NUM_TAPS-1:0] early_hist;
  logic [NUM_TAPS-1:0] late_hist;

  ////////////////////////////////////////
  // Start conditioning and sequencing
  ////////////////////////////////////////
  lp_start_detect #(.PWRUP_BITS(PWRUP_BITS)) u_lp_start_detect (
    .sclk, .reset, .lp_in, .skip_trng, .arm, .lp_start, .skip
  );

  training_sequencer #(.FAIL_LIMIT(FAIL_LIMIT)) u_training_sequencer (
    .sclk, .reset, .arm, .lp_start, .skip, .sweep_done, .search_done,
    .found, .load_done, .best, .center, .sweep_go, .search_go, .load_go,
    .target, .trng_done, .trng_fail, .window, .set_index
  );

  ////////////////////////////////////////
  // Delay line engine and window search
  ////////////////////////////////////////
  tap_sweep u_tap_sweep (
    .sclk, .reset, .sweep_go, .load_go, .target, .iod_status, .iod_ctrl,
    .sweep_done, .load_done, .early_hist, .late_hist
  );

  window_search #(.MIN_WINDOW(MIN_WINDOW)) u_window_search (
    .sclk, .reset, .search_go, .early_hist, .late_hist,
    .search_done, .found, .best, .center
  );

endmodule

/* rtl/lp_start_detect.sv */
////////////////////////////////////////
// Training start conditioning
// Power-up hold-off, low-power falling edge
// detect with stretch, skip synchronizer
////////////////////////////////////////
`timescale 1ns/10ps

module lp_start_detect #(
  parameter int PWRUP_BITS = 10 // Hold-off of 2**PWRUP_BITS cycles
) (
  input  logic sclk,
  input  logic reset,
  input  logic lp_in,
  input  logic skip_trng,
  output logic arm,
  output logic lp_start,
  output logic skip
);

  logic [PWRUP_BITS-1:0] pwrup_cnt;
  logic [2:0]            lp_reg;   // [0] sync flop, [2:1] edge pair
  logic [3:0]            edge_reg; // Stretch of the falling edge
  logic [2:0]            skip_reg;
  logic                  lp_fall;

  // Power-up delay, arm stays set until reset
  always_ff @(posedge sclk) begin
    if (reset) begin
      pwrup_cnt <= '0;
      arm       <= 1'b0;
    end else if (!arm) begin
      pwrup_cnt <= pwrup_cnt + 1'b1;
      if (&pwrup_cnt)
        arm <= 1'b1;
    end
  end

  assign lp_fall  = lp_reg[2] & ~lp_reg[1]; // High to low on the lane
  assign lp_start = |edge_reg;              // Four cycles wide

  // Edge logic frozen until armed
  always_ff @(posedge sclk) begin
    if (reset) begin
      lp_reg   <= 3'b111; // Lane idles high in LP
      edge_reg <= 4'h0;
    end else if (arm) begin
      lp_reg   <= {lp_reg[1:0], lp_in};
      edge_reg <= {edge_reg[2:0], lp_fall};
    end
  end

  // Three-flop skip sync
  always_ff @(posedge sclk) begin
    if (reset)
      skip_reg <= 3'b000;
    else
      skip_reg <= {skip_reg[1:0], skip_trng};
  end

  assign skip = skip_reg[2];

endmodule

/* rtl/tap_sweep.sv */
////////////////////////////////////////
// Delay line sweep and load engine
// Slot-paced tap stepping, flag history
// capture, and final move to target tap
////////////////////////////////////////
`timescale 1ns/10ps

module tap_sweep import bit_align_pkg::*; (
  input  logic                sclk,
  input  logic                reset,
  input  logic                sweep_go,
  input  logic                load_go,
  input  tap_t                target,
  input  iod_status_t         iod_status,
  output iod_ctrl_t           iod_ctrl,
  output logic                sweep_done,
  output logic                load_done,
  output logic [NUM_TAPS-1:0] early_hist,
  output logic [NUM_TAPS-1:0] late_hist
);

  typedef enum logic [1:0] {S_IDLE, S_LOAD, S_STEP} state_t;

  state_t     state;
  logic [1:0] slot;     // Free running, one step per wrap
  tap_t       tap;      // Mirror of the controller tap
  logic       sweeping; // 0 while loading to target
  logic       first;    // Tap 0 not yet sampled
  logic       oor_q;    // oor seen at last sample

  always_ff @(posedge sclk) begin
    if (reset)
      slot <= 2'd0;
    else
      slot <= slot + 2'd1;
  end

  ////////////////////////////////////////
  // Step FSM
  ////////////////////////////////////////
  // Slot 0 clr or load, slot 1 move, slot 3 sample
  always_ff @(posedge sclk) begin
    if (reset) begin
      state      <= S_IDLE;
      iod_ctrl   <= '{load: 1'b1, move: 1'b0, dir: 1'b1, clr_flags: 1'b1};
      tap        <= '0;
      sweeping   <= 1'b0;
      first      <= 1'b0;
      oor_q      <= 1'b0;
      sweep_done <= 1'b0;
      load_done  <= 1'b0;
    end else begin
      iod_ctrl.move <= 1'b0; // Single-cycle move
      sweep_done    <= 1'b0;
      load_done     <= 1'b0;
      case (state)
        S_IDLE: if (sweep_go || load_go) begin
          sweeping <= sweep_go;
          state    <= S_LOAD;
        end
        S_LOAD: if (slot == 2'd3) begin
          iod_ctrl.load      <= 1'b1; // High for slot 0
          iod_ctrl.clr_flags <= 1'b1;
          iod_ctrl.dir       <= 1'b1;
          tap                <= '0;
          first              <= 1'b1;
          state              <= S_STEP;
        end
        default: begin
          if (slot == 2'd0) begin
            iod_ctrl.load      <= 1'b0;
            iod_ctrl.clr_flags <= 1'b0;
            if (sweeping ? (!first && oor_q) : (tap == target)) begin
              sweep_done <= sweeping;
              load_done  <= !sweeping;
              state      <= S_IDLE;
            end else if (!(sweeping && first)) begin
              iod_ctrl.move <= 1'b1;
              tap           <= tap + 1'b1;
            end
          end else if (slot == 2'd3 && sweeping) begin
            oor_q              <= iod_status.oor;
            first              <= 1'b0;
            iod_ctrl.clr_flags <= 1'b1; // Fresh flags for the next tap
          end
        end
      endcase
    end
  end

  // Flag history, one pair per tap
  always_ff @(posedge sclk) begin
    if (state == S_STEP && slot == 2'd3 && sweeping) begin
      early_hist[tap] <= iod_status.early;
      late_hist[tap]  <= iod_status.late;
    end
  end

endmodule

/* rtl/training_sequencer.sv */
////////////////////////////////////////
// Training state sequencing
// Runs sweep, search and final load, counts
// failed attempts, drives done and fail
////////////////////////////////////////
`timescale 1ns/10ps

module training_sequencer import bit_align_pkg::*; #(
  parameter int FAIL_LIMIT = 4 // Failed attempts before fail
) (
  input  logic    sclk,
  input  logic    reset,
  input  logic    arm,
  input  logic    lp_start,
  input  logic    skip,
  input  logic    sweep_done,
  input  logic    search_done,
  input  logic    found,
  input  logic    load_done,
  input  window_t best,
  input  tap_t    center,
  output logic    sweep_go,
  output logic    search_go,
  output logic    load_go,
  output tap_t    target,
  output logic    trng_done,
  output logic    trng_fail,
  output window_t window,
  output tap_t    set_index
);

  localparam int FAIL_W = $clog2(FAIL_LIMIT + 1);

  typedef enum logic [2:0] {
    ST_IDLE, ST_SWEEP, ST_SEARCH, ST_LOAD, ST_DONE, ST_FAILED
  } state_t;

  state_t            state;
  logic              done_q;
  logic [FAIL_W-1:0] fail_cnt;
  window_t           win_q; // Winner held during the load

  assign trng_done = done_q | skip; // Skip overrides training

  ////////////////////////////////////////
  // Main FSM
  ////////////////////////////////////////
  always_ff @(posedge sclk) begin
    if (reset) begin
      state     <= ST_IDLE;
      sweep_go  <= 1'b0;
      search_go <= 1'b0;
      load_go   <= 1'b0;
      done_q    <= 1'b0;
      trng_fail <= 1'b0;
      fail_cnt  <= '0;
      window    <= '0;
      set_index <= '0;
    end else begin
      sweep_go  <= 1'b0; // Go strobes last one cycle
      search_go <= 1'b0;
      load_go   <= 1'b0;
      case (state)
        ST_IDLE: if (arm && !skip && lp_start) begin
          sweep_go <= 1'b1;
          state    <= ST_SWEEP;
        end
        ST_SWEEP: if (sweep_done) begin
          search_go <= 1'b1;
          state     <= ST_SEARCH;
        end
        ST_SEARCH: if (search_done) begin
          if (found) begin
            load_go <= 1'b1;
            state   <= ST_LOAD;
          end else begin
            fail_cnt <= fail_cnt + 1'b1;
            if (fail_cnt == FAIL_W'(FAIL_LIMIT - 1)) begin
              trng_fail <= 1'b1; // Out of attempts
              state     <= ST_FAILED;
            end else begin
              state <= ST_IDLE; // Wait for the next LP edge
            end
          end
        end
        ST_LOAD: if (load_done) begin
          done_q    <= 1'b1;
          window    <= win_q;
          set_index <= target;
          state     <= ST_DONE;
        end
        default: ; // Done and failed hold until reset
      endcase
    end
  end

  // Winner capture at search end
  always_ff @(posedge sclk) begin
    if (state == ST_SEARCH && search_done && found) begin
      win_q  <= best;
      target <= center;
    end
  end

endmodule

/* rtl/window_search.sv */
////////////////////////////////////////
// Eye window search
// Finds flag-free runs in the history, keeps
// the first qualifying ones, picks the widest
////////////////////////////////////////
`timescale 1ns/10ps

module window_search import bit_align_pkg::*; #(
  parameter int MIN_WINDOW = 10 // Minimum last minus first
) (
  input  logic                sclk,
  input  logic                reset,
  input  logic                search_go,
  input  logic [NUM_TAPS-1:0] early_hist,
  input  logic [NUM_TAPS-1:0] late_hist,
  output logic                search_done,
  output logic                found,
  output window_t             best,
  output tap_t                center
);

  localparam int CNT_W = $clog2(MAX_WINDOWS + 1);

  typedef enum logic [1:0] {W_IDLE, W_SCAN, W_PICK} state_t;

  state_t           state;
  tap_t             idx;       // Scan position
  tap_t             run_first; // Start of the open run
  logic             in_run;
  window_t          wins [MAX_WINDOWS];
  logic [CNT_W-1:0] win_cnt;
  logic             open_now;
  logic             close_now;
  logic             cand_ok;
  window_t          cand;
  tap_t             cand_len;
  window_t          pick;
  tap_t             pick_len;
  logic [7:0]       mid_sum;   // One bit extra for the carry
  logic             start_run;
  logic             store_en;

  ////////////////////////////////////////
  // Run tracking at the scan index
  ////////////////////////////////////////
  always_comb begin
    open_now  = !(early_hist[idx] | late_hist[idx]);
    close_now = 1'b0;
    cand      = '0;
    if (open_now && idx == tap_t'(NUM_TAPS - 1)) begin // Run reaching the top
      close_now  = 1'b1;
      cand.first = in_run ? run_first : idx;
      cand.last  = idx;
    end else if (!open_now && in_run) begin // Run ended one tap back
      close_now  = 1'b1;
      cand.first = run_first;
      cand.last  = idx - 1'b1;
    end
    cand_len = cand.last - cand.first;
    cand_ok  = close_now && (cand_len >= tap_t'(MIN_WINDOW));
  end

  assign start_run = (state == W_SCAN) && open_now && !in_run;
  assign store_en  = (state == W_SCAN) && cand_ok && (win_cnt < MAX_WINDOWS);

  // Widest stored window, strict compare keeps the earlier one
  always_comb begin
    tap_t len_i;
    pick     = wins[0];
    pick_len = wins[0].last - wins[0].first;
    for (int i = 1; i < MAX_WINDOWS; i++) begin
      len_i = wins[i].last - wins[i].first;
      if (i < win_cnt && len_i > pick_len) begin
        pick     = wins[i];
        pick_len = len_i;
      end
    end
  end

  assign mid_sum = {1'b0, pick.first} + {1'b0, pick.last};

  always_ff @(posedge sclk) begin
    if (reset) begin
      state       <= W_IDLE;
      idx         <= '0;
      in_run      <= 1'b0;
      win_cnt     <= '0;
      search_done <= 1'b0;
      found       <= 1'b0;
      best        <= '0;
      center      <= '0;
    end else begin
      search_done <= 1'b0;
      case (state)
        W_IDLE: if (search_go) begin
          idx     <= '0;
          in_run  <= 1'b0;
          win_cnt <= '0;
          state   <= W_SCAN;
        end
        W_SCAN: begin
          in_run <= open_now;
          if (store_en)
            win_cnt <= win_cnt + 1'b1;
          if (idx == tap_t'(NUM_TAPS - 1))
            state <= W_PICK;
          else
            idx <= idx + 1'b1;
        end
        default: begin // Result out with the done strobe
          found       <= (win_cnt != '0);
          best        <= (win_cnt != '0) ? pick : '0;
          center      <= (win_cnt != '0) ? mid_sum[7:1] : '0; // Rounded down
          search_done <= 1'b1;
          state       <= W_IDLE;
        end
      endcase
    end
  end

  // Run start and window store
  always_ff @(posedge sclk) begin
    if (start_run)
      run_first <= idx;
    if (store_en)
      wins[win_cnt] <= cand;
  end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the trainer testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
  --top-module tb_iod_bit_training -f iod_bit_training.f -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "=== FAIL ===" sim.log || ! grep -q "=== PASS ===" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi
echo "Simulation passed"

/* testbench/iod_bit_training_assertions.sv */
////////////////////////////////////////
// Delay controller protocol checks
// Bound into the sweep and load engine
////////////////////////////////////////
`timescale 1ns/10ps

module iod_bit_training_assertions import bit_align_pkg::*; (
  input logic        sclk,
  input logic        reset,
  input iod_ctrl_t   iod_ctrl,
  input iod_status_t iod_status,
  input logic [1:0]  state,
  input logic [1:0]  slot,
  input logic        sweeping
);

  logic sample_now; // History written this cycle

  assign sample_now = (state == 2'd2) && (slot == 2'd3) && sweeping; // Step state, slot end

  move_not_with_load: assert property (@(posedge sclk) disable iff (reset)
    !(iod_ctrl.move && iod_ctrl.load))
    else $error("move and load high in the same cycle");

  clr_after_sample: assert property (@(posedge sclk) disable iff (reset)
    sample_now |=> iod_ctrl.clr_flags)
    else $error("clr_flags low in the cycle after a history sample");

  // No step past the top tap
  no_move_at_top: assert property (@(posedge sclk) disable iff (reset)
    !(iod_ctrl.move && iod_ctrl.dir && iod_status.oor))
    else $error("upward move while oor is high");

endmodule

bind tap_sweep iod_bit_training_assertions u_assertions (
  .sclk(sclk), .reset(reset), .iod_ctrl(iod_ctrl), .iod_status(iod_status),
  .state(state), .slot(slot), .sweeping(sweeping)
);

/* testbench/iod_monitor.sv */
////////////////////////////////////////
// Trainer result checker
// Watches the DUT through each test, compares
// at test end and keeps the totals
////////////////////////////////////////
`timescale 1ns/10ps

module iod_monitor import bit_align_pkg::*; (
  input  logic       sclk,
  input  logic       reset,
  input  logic       test_start,
  input  logic       test_check,
  input  logic       summary_req,
  input  int         test_num,
  input  logic [1:0] kind,
  input  window_t    exp_window,
  input  tap_t       exp_index,
  input  tap_t       model_tap,
  input  iod_ctrl_t  iod_ctrl,
  input  logic       trng_done,
  input  logic       trng_fail,
  input  window_t    window,
  input  tap_t       set_index,
  output int         errors
);

  localparam logic [1:0] K_DONE = 2'd0;
  localparam logic [1:0] K_FAIL = 2'd1;
  localparam logic [1:0] K_SKIP = 2'd2;

  int   test_errs    = 0;
  int   total_errs   = 0;
  int   passed       = 0;
  int   failed       = 0;
  logic move_seen    = 1'b0; // Sticky over one test
  logic done_seen    = 1'b0;
  logic fail_seen    = 1'b0;
  logic fail_dropped = 1'b0;

  assign errors = total_errs;

  task automatic check_value(input string name, input int got, input int want);
    if (got != want) begin
      $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, name, got, want);
      test_errs++;
    end
  endtask

  task automatic report_if(input logic bad, input string what);
    if (bad) begin
      $display("Test %0d: %s", test_num, what);
      test_errs++;
    end
  endtask

  always @(posedge sclk) begin
    if (test_start) begin
      test_errs    = 0;
      move_seen    = 1'b0;
      done_seen    = 1'b0;
      fail_seen    = 1'b0;
      fail_dropped = 1'b0;
    end else if (!reset) begin
      if (iod_ctrl.move)
        move_seen = 1'b1;
      if (trng_done)
        done_seen = 1'b1;
      if (fail_seen && !trng_fail)
        fail_dropped = 1'b1; // Fail must hold until reset
      if (trng_fail)
        fail_seen = 1'b1;
    end

    ////////////////////////////////////////
    // End of test compare
    ////////////////////////////////////////
    if (test_check) begin
      case (kind)
        K_DONE: begin
          check_value("trng_done", int'(trng_done), 1);
          check_value("trng_fail", int'(trng_fail), 0);
          check_value("window.first", int'(window.first), int'(exp_window.first));
          check_value("window.last", int'(window.last), int'(exp_window.last));
          check_value("set_index", int'(set_index), int'(exp_index));
          check_value("model tap", int'(model_tap), int'(exp_index)); // Tap parked there
        end
        K_FAIL: begin
          check_value("trng_fail", int'(trng_fail), 1);
          check_value("trng_done", int'(trng_done), 0);
          report_if(done_seen, "trng_done went high although no window qualified");
          report_if(fail_dropped, "trng_fail fell again before reset");
        end
        K_SKIP: begin
          check_value("trng_done", int'(trng_done), 1);
          check_value("window", int'(window), 0);
          check_value("set_index", int'(set_index), 0);
          report_if(move_seen, "iod_ctrl.move pulsed although training was skipped");
        end
        default: begin // lp_in held high
          check_value("trng_done", int'(trng_done), 0);
          check_value("trng_fail", int'(trng_fail), 0);
          report_if(move_seen, "a sweep started with lp_in held high");
        end
      endcase
      if (test_errs == 0) begin
        passed++;
        $display("Test %0d passed", test_num);
      end else begin
        failed++;
        total_errs += test_errs;
        $display("Test %0d failed with %0d errors", test_num, test_errs);
      end
    end

    if (summary_req)
      $display("Tests passed: %0d, failed: %0d, errors: %0d", passed, failed, total_errs);
  end

endmodule

/* testbench/tb_iod_bit_training.sv */
////////////////////////////////////////
// Bit-alignment trainer testbench
// Delay line model, stimulus table, lp_in
// activity and the cycle limit
////////////////////////////////////////
`timescale 1ns/10ps

module tb_iod_bit_training import bit_align_pkg::*; ();

  localparam int NUM_ROWS     = 7;
  localparam int FAIL_LIMIT   = 2;
  localparam int RESET_CYCLES = 8;
  localparam int HOLD_CYCLES  = 80;  // Watch after done or fail
  localparam int IDLE_CYCLES  = 600; // Longer than a whole sweep
  localparam int CYCLE_LIMIT  = NUM_ROWS * FAIL_LIMIT * 1800;

  localparam logic [1:0] K_DONE = 2'd0; // Trained to a window
  localparam logic [1:0] K_FAIL = 2'd1; // Out of attempts
  localparam logic [1:0] K_SKIP = 2'd2; // Skip forces done
  localparam logic [1:0] K_IDLE = 2'd3; // Never starts

  // Noise band flags early, empty when lo > hi
  typedef struct packed {
    tap_t       eye_lo;
    tap_t       eye_hi;
    tap_t       n0_lo;
    tap_t       n0_hi;
    tap_t       n1_lo;
    tap_t       n1_hi;
    logic       skip;
    logic [1:0] kind;
    tap_t       exp_first;
    tap_t       exp_last;
    tap_t       exp_index;
  } test_row_t;

  ////////////////////////////////////////
  // Stimulus and expected results
  ////////////////////////////////////////
  localparam test_row_t ROWS [NUM_ROWS] = '{
    '{30, 70,  1,  0,  1,  0, 0, K_DONE, 30,  70, 50}, // Single clean eye
    '{21, 85, 41, 45, 66, 70, 0, K_DONE, 21,  40, 30}, // Tie, earlier wins
    '{10, 110, 25, 29, 50, 54, 0, K_DONE, 55, 110, 82}, // Third is widest
    '{10, 60, 16, 20, 55, 57, 0, K_DONE, 21,  54, 37}, // Narrow runs dropped
    '{40, 60, 45, 49, 54, 55, 0, K_FAIL,  0,   0,  0}, // All runs too narrow
    '{30, 70,  1,  0,  1,  0, 1, K_SKIP,  0,   0,  0}, // Skip
    '{30, 70,  1,  0,  1,  0, 0, K_IDLE,  0,   0,  0}  // lp_in held high
  };

  logic        sclk;
  logic        reset;
  logic        lp_in;
  logic        skip_trng;
  iod_status_t iod_status;
  iod_ctrl_t   iod_ctrl;
  logic        trng_done;
  logic        trng_fail;
  window_t     window;
  tap_t        set_index;
  test_row_t   cur;
  window_t     exp_window;
  tap_t        model_tap = '0; // Delay line tap
  logic        m_early   = 1'b0;
  logic        m_late    = 1'b0;
  logic        test_start;
  logic        test_check;
  logic        summary_req;
  int          test_num;
  int          errors;
  int          cycles = 0;

  initial begin
    sclk = 1'b0;
    forever #10 sclk = ~sclk;
  end

  iod_bit_training #(.FAIL_LIMIT(FAIL_LIMIT), .PWRUP_BITS(4)) uut (
    .sclk, .reset, .lp_in, .skip_trng, .iod_status, .iod_ctrl,
    .trng_done, .trng_fail, .window, .set_index
  );

  assign exp_window = '{first: cur.exp_first, last: cur.exp_last};

  iod_monitor u_monitor (
    .sclk, .reset, .test_start, .test_check, .summary_req, .test_num,
    .kind(cur.kind), .exp_window, .exp_index(cur.exp_index), .model_tap,
    .iod_ctrl, .trng_done, .trng_fail, .window, .set_index, .errors
  );

  ////////////////////////////////////////
  // Delay line model
  ////////////////////////////////////////
  function automatic logic in_band(tap_t t, tap_t lo, tap_t hi);
    return (t >= lo) && (t <= hi);
  endfunction

  function automatic logic early_at(tap_t t);
    return (t < cur.eye_lo) || in_band(t, cur.n0_lo, cur.n0_hi) ||
           in_band(t, cur.n1_lo, cur.n1_hi);
  endfunction

  function automatic logic late_at(tap_t t);
    return t > cur.eye_hi;
  endfunction

  always @(posedge sclk) begin
    tap_t nxt;
    nxt = model_tap;
    if (iod_ctrl.load)
      nxt = '0;
    else if (iod_ctrl.move)
      nxt = iod_ctrl.dir ? nxt + 1'b1 : nxt - 1'b1;
    model_tap <= nxt;
    if (iod_ctrl.clr_flags) begin // Sticky flags cleared while held
      m_early <= 1'b0;
      m_late  <= 1'b0;
    end else begin
      m_early <= m_early | early_at(nxt);
      m_late  <= m_late | late_at(nxt);
    end
  end

  assign iod_status = '{early: m_early, late: m_late, oor: (model_tap == 7'd127)};

  // One clock of lp_in activity, flips the line when the gap runs out
  task automatic lp_step(inout int gap);
    @(posedge sclk);
    if (gap == 0) begin
      lp_in <= ~lp_in;
      gap = 2 + int'($urandom % 8); // 2 to 9 cycles
    end
    gap--;
  endtask

  task automatic run_row(input int r);
    int gap;
    @(posedge sclk);
    reset      <= 1'b1;
    cur        <= ROWS[r];
    skip_trng  <= ROWS[r].skip;
    lp_in      <= 1'b1;
    test_num   <= r;
    test_start <= 1'b1;
    @(posedge sclk);
    test_start <= 1'b0;
    repeat (RESET_CYCLES - 1) @(posedge sclk);
    reset <= 1'b0;
    gap = 0;
    if (ROWS[r].kind == K_IDLE) begin
      repeat (IDLE_CYCLES) @(posedge sclk); // No edge, so nothing to wait on
    end else begin
      while (!(trng_done || trng_fail))
        lp_step(gap);
      repeat (HOLD_CYCLES) lp_step(gap);
    end
    test_check <= 1'b1;
    @(posedge sclk);
    test_check <= 1'b0;
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////
  initial begin
    void'($urandom(32'he6df_6654));
    reset       = 1'b1;
    lp_in       = 1'b1;
    skip_trng   = 1'b0;
    cur         = ROWS[0];
    test_start  = 1'b0;
    test_check  = 1'b0;
    summary_req = 1'b0;
    test_num    = 0;
    for (int r = 0; r < NUM_ROWS; r++)
      run_row(r);
    @(posedge sclk);
    summary_req <= 1'b1;
    @(posedge sclk);
    summary_req <= 1'b0;
    repeat (2) @(posedge sclk);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

  // Run limit
  always @(posedge sclk) begin
    cycles <= cycles + 1;
    if (cycles == CYCLE_LIMIT) begin
      $display("Run stopped, no result after %0d cycles", CYCLE_LIMIT);
      $display("=== FAIL ===");
      $finish;
    end
  end

endmodule
